/* include/display_params.svh */
`ifndef DISPLAY_PARAMS_SVH
`define DISPLAY_PARAMS_SVH

// signed screen coordinate width in bits
`define DISP_CORDW 16

// video mode, fixed at build time
//  0  640x480
//  1  1024x768
//  2  1366x768
//  3  672x384, small enough for simulation
//  4  1280x720
`define DISP_MODE 3

// bits per colour channel, three channels per pixel
`define DISP_CHANW 4

`endif

/* hw/display_pkg.sv */
`include "display_params.svh"

package display_pkg;

    localparam int n_modes = 5;  // rows in the timing tables

    // horizontal timing per mode, active area starts at x = 0
    localparam int hres   [n_modes] = '{ 640, 1024, 1366,  672, 1280};  // active pixels
    localparam int h_sta  [n_modes] = '{-160, -320, -134, -128, -370};  // line start, blanking
    localparam int hs_sta [n_modes] = '{-144, -296, -120, -112, -260};  // after front porch
    localparam int hs_end [n_modes] = '{ -48, -160,  -64,  -48, -220};  // first x past sync
    localparam int ha_end [n_modes] = '{ 639, 1023, 1365,  671, 1279};  // last active x
    localparam bit h_pol  [n_modes] = '{1'b0, 1'b0, 1'b1, 1'b1, 1'b1};  // 1 for positive

    // vertical timing per mode, active area starts at y = 0
    localparam int vres   [n_modes] = '{ 480,  768,  768,  384,  720};  // active lines
    localparam int v_sta  [n_modes] = '{ -45,  -38,  -32, -137,  -30};  // frame start
    localparam int vs_sta [n_modes] = '{ -35,  -35,  -31, -127,  -25};
    localparam int vs_end [n_modes] = '{ -33,  -29,  -28, -125,  -20};
    localparam int va_end [n_modes] = '{ 479,  767,  767,  383,  719};  // last active line
    localparam bit v_pol  [n_modes] = '{1'b0, 1'b0, 1'b1, 1'b1, 1'b1};

    // test pattern
    localparam int bar_shift = 6;                // 64 pixel wide bars
    localparam int colw      = 3 * `DISP_CHANW;  // packed {r, g, b}

    localparam logic [colw-1:0] bar_colour [8] = '{
        12'h000,  // black
        12'h00f,  // blue
        12'h0f0,  // green
        12'h0ff,  // cyan
        12'hf00,  // red
        12'hf0f,  // magenta
        12'hff0,  // yellow
        12'hfff   // white
    };

    localparam logic [colw-1:0] border_colour = 12'hfff;  // one pixel frame around screen

endpackage

/* hw/display.sv */
`timescale 1ns/1ps
`include "display_params.svh"

module display #(
    parameter int CORDW = `DISP_CORDW,  // signed coordinate width
    parameter int MODE  = 0             // row of the display_pkg timing tables
) (
    input  logic                    clk_pix,
    input  logic                    rst_pix,
    output logic signed [CORDW-1:0] hres,        // active width
    output logic signed [CORDW-1:0] vres,        // active height
    output logic signed [CORDW-1:0] dx,          // current x, negative in blanking
    output logic signed [CORDW-1:0] dy,          // current y, negative in blanking
    output logic                    hsync,
    output logic                    vsync,
    output logic                    de,          // high inside the active area
    output logic                    frame_start, // one cycle at first position of frame
    output logic                    line_start   // one cycle at first position of line
);

    // unknown modes fall back to 640x480
    localparam int mi = (MODE >= 0 && MODE < display_pkg::n_modes) ? MODE : 0;

    logic signed [CORDW-1:0] x;  // scan position, one cycle ahead of dx
    logic signed [CORDW-1:0] y;

    // timing registers, loaded from the table row
    logic signed [CORDW-1:0] h_sta;
    logic signed [CORDW-1:0] hs_sta;
    logic signed [CORDW-1:0] hs_end;
    logic signed [CORDW-1:0] ha_end;
    logic signed [CORDW-1:0] v_sta;
    logic signed [CORDW-1:0] vs_sta;
    logic signed [CORDW-1:0] vs_end;
    logic signed [CORDW-1:0] va_end;
    logic                    h_pol;  // 1 = positive sync
    logic                    v_pol;

    logic hs_act;  // x inside the sync pulse
    logic vs_act;

    always_comb begin
        hs_act = (x >= hs_sta) && (x < hs_end);
        vs_act = (y >= vs_sta) && (y < vs_end);
    end

    // syncs, registered so they line up with dx/dy
    always_ff @(posedge clk_pix) begin
        if (rst_pix) begin
            hsync <= !h_pol;  // inactive level
            vsync <= !v_pol;
        end else begin
            hsync <= h_pol ? hs_act : !hs_act;
            vsync <= v_pol ? vs_act : !vs_act;
        end
    end

    // enable and start pulses
    always_ff @(posedge clk_pix) begin
        if (rst_pix) begin
            de          <= 1'b0;
            frame_start <= 1'b1;  // reset leaves us at position 0
            line_start  <= 1'b1;
        end else begin
            de          <= (x >= 0) && (y >= 0);
            frame_start <= (x == h_sta) && (y == v_sta);
            line_start  <= (x == h_sta);
        end
    end

    // scan counters
    always_ff @(posedge clk_pix) begin
        if (rst_pix) begin
            x <= h_sta + CORDW'(1);  // position 0 already sits on dx
            y <= v_sta;
        end else if (x == ha_end) begin  // end of line
            x <= h_sta;
            y <= (y == va_end) ? v_sta : y + CORDW'(1);  // wrap at end of frame
        end else begin
            x <= x + CORDW'(1);
        end
    end

    // visible position, one cycle behind x/y
    always_ff @(posedge clk_pix) begin
        if (rst_pix) begin
            dx <= h_sta;
            dy <= v_sta;
        end else begin
            dx <= x;
            dy <= y;
        end
    end

    // mode timings, constant after the first edge
    always_ff @(posedge clk_pix) begin
        hres   <= CORDW'(display_pkg::hres[mi]);
        vres   <= CORDW'(display_pkg::vres[mi]);
        h_sta  <= CORDW'(display_pkg::h_sta[mi]);
        hs_sta <= CORDW'(display_pkg::hs_sta[mi]);
        hs_end <= CORDW'(display_pkg::hs_end[mi]);
        ha_end <= CORDW'(display_pkg::ha_end[mi]);
        h_pol  <= display_pkg::h_pol[mi];
        v_sta  <= CORDW'(display_pkg::v_sta[mi]);
        vs_sta <= CORDW'(display_pkg::vs_sta[mi]);
        vs_end <= CORDW'(display_pkg::vs_end[mi]);
        va_end <= CORDW'(display_pkg::va_end[mi]);
        v_pol  <= display_pkg::v_pol[mi];
    end

    // de comes from x/y, dx/dy from a separate register stage
    de_in_active: assert property (
        @(posedge clk_pix) disable iff (rst_pix)
        de |-> (dx >= 0 && dy >= 0)
    );

    // every frame begins with a line
    frame_has_line: assert property (
        @(posedge clk_pix)
        frame_start |-> line_start
    );

endmodule

/* hw/test_pattern.sv */
`timescale 1ns/1ps
`include "display_params.svh"

module test_pattern #(
    parameter int CORDW = `DISP_CORDW  // signed coordinate width
) (
    input  logic                    clk_pix,
    input  logic                    rst_pix,
    input  logic signed [CORDW-1:0] dx,          // position to colour
    input  logic signed [CORDW-1:0] dy,
    input  logic signed [CORDW-1:0] hres,        // active width
    input  logic signed [CORDW-1:0] vres,        // active height
    input  logic                    frame_start, // bumps the scroll offset
    output logic [`DISP_CHANW-1:0]  pix_r,
    output logic [`DISP_CHANW-1:0]  pix_g,
    output logic [`DISP_CHANW-1:0]  pix_b
);

    logic [2:0]                 frame_cnt;  // scroll offset in bars, wraps at 8
    logic [2:0]                 bar_idx;    // entry in the bar table
    logic                       on_border;  // outermost row or column
    logic [3*`DISP_CHANW-1:0]   colour;     // packed {r, g, b}

    // scroll by one bar each frame
    always_ff @(posedge clk_pix) begin
        if (rst_pix) begin
            frame_cnt <= 3'd0;
        end else if (frame_start) begin
            frame_cnt <= frame_cnt + 3'd1;
        end
    end

    always_comb begin
        on_border = (dx == 0) || (dx == hres - 1)
                 || (dy == 0) || (dy == vres - 1);
        bar_idx   = 3'(dx >>> display_pkg::bar_shift) + frame_cnt;  // mod 8 by width
        if (on_border) begin
            colour = display_pkg::border_colour;
        end else begin
            colour = display_pkg::bar_colour[bar_idx];
        end
    end

    // blanking happens downstream, negative positions give junk here
    always_ff @(posedge clk_pix) begin
        {pix_r, pix_g, pix_b} <= colour;
    end

endmodule

/* hw/sync_align.sv */
`timescale 1ns/1ps
`include "display_params.svh"

module sync_align (
    input  logic                   clk_pix,
    input  logic                   rst_pix,
    input  logic                   hsync,      // from display, one cycle ahead of colour
    input  logic                   vsync,
    input  logic                   de,
    input  logic [`DISP_CHANW-1:0] pix_r,      // registered colour
    input  logic [`DISP_CHANW-1:0] pix_g,
    input  logic [`DISP_CHANW-1:0] pix_b,
    output logic                   vga_hsync,
    output logic                   vga_vsync,
    output logic                   vga_de,
    output logic [`DISP_CHANW-1:0] vga_r,
    output logic [`DISP_CHANW-1:0] vga_g,
    output logic [`DISP_CHANW-1:0] vga_b
);

    // match the colour pipeline stage
    always_ff @(posedge clk_pix) begin
        if (rst_pix) begin
            vga_hsync <= !display_pkg::h_pol[`DISP_MODE];  // inactive polarity
            vga_vsync <= !display_pkg::v_pol[`DISP_MODE];
            vga_de    <= 1'b0;
        end else begin
            vga_hsync <= hsync;
            vga_vsync <= vsync;
            vga_de    <= de;
        end
    end

    // de that came in with this colour, now in vga_de
    always_comb begin
        vga_r = vga_de ? pix_r : '0;  // black in blanking
        vga_g = vga_de ? pix_g : '0;
        vga_b = vga_de ? pix_b : '0;
    end

    // nothing lit outside the active area
    lit_only_active: assert property (
        @(posedge clk_pix) disable iff (rst_pix)
        (vga_r != '0 || vga_g != '0 || vga_b != '0) |-> vga_de
    );

endmodule

/* hw/display_top.sv */
`timescale 1ns/1ps
`include "display_params.svh"

module display_top (
    input  logic                   clk_pix,
    input  logic                   rst_pix,
    output logic                   vga_hsync,
    output logic                   vga_vsync,
    output logic                   vga_de,
    output logic [`DISP_CHANW-1:0] vga_r,
    output logic [`DISP_CHANW-1:0] vga_g,
    output logic [`DISP_CHANW-1:0] vga_b,
    output logic                   frame_start,  // one cycle ahead of the video
    output logic                   line_start
);

    logic signed [`DISP_CORDW-1:0] hres;
    logic signed [`DISP_CORDW-1:0] vres;
    logic signed [`DISP_CORDW-1:0] dx;
    logic signed [`DISP_CORDW-1:0] dy;
    logic                          hsync;  // raw timing, before alignment
    logic                          vsync;
    logic                          de;
    logic [`DISP_CHANW-1:0]        pix_r;  // unblanked pattern colour
    logic [`DISP_CHANW-1:0]        pix_g;
    logic [`DISP_CHANW-1:0]        pix_b;

    display #(
        .CORDW (`DISP_CORDW),
        .MODE  (`DISP_MODE)
    ) u_display (
        .clk_pix     (clk_pix),
        .rst_pix     (rst_pix),
        .hres        (hres),
        .vres        (vres),
        .dx          (dx),
        .dy          (dy),
        .hsync       (hsync),
        .vsync       (vsync),
        .de          (de),
        .frame_start (frame_start),
        .line_start  (line_start)
    );

    test_pattern #(
        .CORDW (`DISP_CORDW)
    ) u_test_pattern (
        .clk_pix     (clk_pix),
        .rst_pix     (rst_pix),
        .dx          (dx),
        .dy          (dy),
        .hres        (hres),
        .vres        (vres),
        .frame_start (frame_start),
        .pix_r       (pix_r),
        .pix_g       (pix_g),
        .pix_b       (pix_b)
    );

    sync_align u_sync_align (
        .clk_pix   (clk_pix),
        .rst_pix   (rst_pix),
        .hsync     (hsync),
        .vsync     (vsync),
        .de        (de),
        .pix_r     (pix_r),
        .pix_g     (pix_g),
        .pix_b     (pix_b),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_de    (vga_de),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b)
    );

endmodule

/* tests/display_tb.sv */
`timescale 1ns/1ps
`include "display_params.svh"

module display_tb;

    localparam int mode   = `DISP_MODE;
    localparam int colw   = 3 * `DISP_CHANW;         // packed {r, g, b}
    localparam int vidw   = colw + 3;                // {hsync, vsync, de, colour}
    localparam int h_sta  = display_pkg::h_sta[mode];
    localparam int hs_sta = display_pkg::hs_sta[mode];
    localparam int hs_end = display_pkg::hs_end[mode];
    localparam int ha_end = display_pkg::ha_end[mode];
    localparam int v_sta  = display_pkg::v_sta[mode];
    localparam int vs_sta = display_pkg::vs_sta[mode];
    localparam int vs_end = display_pkg::vs_end[mode];
    localparam int va_end = display_pkg::va_end[mode];
    localparam bit h_pol  = display_pkg::h_pol[mode];  // 1 for positive sync
    localparam bit v_pol  = display_pkg::v_pol[mode];
    localparam int hres   = display_pkg::hres[mode];
    localparam int vres   = display_pkg::vres[mode];
    localparam int bar_w  = 1 << display_pkg::bar_shift;  // pixels per bar
    localparam int xw     = $clog2(hres);
    localparam int htot   = ha_end - h_sta + 1;       // clocks per line
    localparam int vtot   = va_end - v_sta + 1;       // lines per frame
    localparam int ftot   = htot * vtot;              // clocks per frame

    localparam int reset_cycles = 4;
    localparam int check_cycles = 2 * ftot + 100;     // two frames and a bit
    localparam int cycle_limit  = reset_cycles + check_cycles + check_cycles / 50;
    localparam int n_tests      = 6;
    localparam int max_shown    = 10;                 // error lines per test

    logic                   clk_pix;
    logic                   rst_pix;
    logic                   vga_hsync;
    logic                   vga_vsync;
    logic                   vga_de;
    logic [`DISP_CHANW-1:0] vga_r;
    logic [`DISP_CHANW-1:0] vga_g;
    logic [`DISP_CHANW-1:0] vga_b;
    logic                   frame_start;
    logic                   line_start;

    int    errs   [n_tests] = '{default: 0};
    int    checks [n_tests] = '{default: 0};
    string test_name [n_tests] = '{"reset state", "sync pulses", "de and blanking",
                                   "pattern content", "scrolling", "start pulses"};

    logic [colw-1:0] first_line [hres];  // expected frame 0 colours of the row below the border

    display_top u_display_top (
        .clk_pix     (clk_pix),
        .rst_pix     (rst_pix),
        .vga_hsync   (vga_hsync),
        .vga_vsync   (vga_vsync),
        .vga_de      (vga_de),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b),
        .frame_start (frame_start),
        .line_start  (line_start)
    );

    initial begin
        clk_pix = 1'b0;
        forever #20 clk_pix = ~clk_pix;  // 25 MHz pixel clock
    end

    initial begin
        rst_pix = 1'b1;
        repeat (reset_cycles) @(posedge clk_pix);
        rst_pix <= 1'b0;  // next edge is edge 0
    end

    // expected {hsync, vsync, de, colour} for scan position p
    function automatic logic [vidw-1:0] expected_video(input int p);
        int              x;
        int              y;
        int              k;
        logic            hs_act;
        logic            vs_act;
        logic            de;
        logic [2:0]      bar;
        logic [colw-1:0] colour;
        x      = h_sta + p % htot;
        y      = v_sta + (p / htot) % vtot;
        k      = p / ftot;  // frame since reset
        hs_act = (x >= hs_sta) && (x < hs_end);
        vs_act = (y >= vs_sta) && (y < vs_end);
        de     = (x >= 0) && (y >= 0);
        colour = '0;  // blanking
        if (de) begin
            if (x == 0 || x == hres - 1 || y == 0 || y == vres - 1) begin
                colour = display_pkg::border_colour;
            end else begin
                bar    = 3'((x / bar_w) + k + 1);  // frame k scrolls by k+1 bars
                colour = display_pkg::bar_colour[bar];
            end
        end
        return {(h_pol ? hs_act : !hs_act), (v_pol ? vs_act : !vs_act), de, colour};
    endfunction

    task automatic check_value(input string name, input int got, input int want, input int t);
        checks[t]++;
        assert (got == want) else begin
            if (errs[t] < max_shown) begin
                $display("ERROR t=%0t %s got %0h expected %0h", $time, name, got, want);
            end
            errs[t]++;
        end
    endtask

    task automatic check_reset_state();
        check_value("vga_de", int'(vga_de), 0, 0);
        check_value("vga colour", int'({vga_r, vga_g, vga_b}), 0, 0);
        check_value("vga_hsync", int'(vga_hsync), int'(!h_pol), 0);  // inactive level
        check_value("vga_vsync", int'(vga_vsync), int'(!v_pol), 0);
    endtask

    task automatic report_test(input int t);
        $display("test %0d %s: %0d checks, %0d failed", t, test_name[t], checks[t], errs[t]);
    endtask

    // compares on the falling edge away from the DUT's updates
    initial begin : compare
        int              i;
        int              c;
        int              cx;
        int              cy;
        int              ck;
        int              lines;
        int              total_checks;
        int              total_errs;
        logic [vidw-1:0] want;
        logic [colw-1:0] got_colour;
        lines = 0;
        for (i = 0; i < reset_cycles; i++) begin
            @(negedge clk_pix);
            check_reset_state();
        end
        for (c = 0; c < check_cycles; c++) begin
            @(negedge clk_pix);  // video now shows position c
            want       = expected_video(c);
            cx         = h_sta + c % htot;
            cy         = v_sta + (c / htot) % vtot;
            ck         = c / ftot;
            got_colour = {vga_r, vga_g, vga_b};
            if (c == 0) begin  // edge that releases reset
                check_reset_state();
                report_test(0);
            end
            check_value("vga_hsync", int'(vga_hsync), int'(want[vidw-1]), 1);
            check_value("vga_vsync", int'(vga_vsync), int'(want[vidw-2]), 1);
            check_value("vga_de", int'(vga_de), int'(want[colw]), 2);
            if (!vga_de) begin
                check_value("vga colour", int'(got_colour), 0, 2);
            end
            if (want[colw]) begin
                check_value("vga colour", int'(got_colour), int'(want[colw-1:0]), 3);
            end
            // frame 1 at x should show what frame 0 shows one bar to the right
            if (cy == 1 && cx >= 1 && cx <= hres - 2) begin
                if (ck == 0) begin
                    first_line[xw'(cx)] = want[colw-1:0];
                end else if (ck == 1 && cx + bar_w <= hres - 2) begin
                    check_value("vga colour scrolled", int'(got_colour),
                                int'(first_line[xw'(cx + bar_w)]), 4);
                end
            end
            if (ck == 1 && cy == 1 && cx == ha_end) begin
                report_test(4);
            end
            // start pulses lead the video by one position
            check_value("frame_start", int'(frame_start), int'((c + 1) % ftot == 0), 5);
            check_value("line_start", int'(line_start), int'((c + 1) % htot == 0), 5);
            if (c < ftot && line_start) begin
                lines++;
            end
            if (c == ftot - 1) begin
                check_value("line_start count", lines, vtot, 5);
            end
        end
        report_test(1);
        report_test(2);
        report_test(3);
        report_test(5);
        total_checks = 0;
        total_errs   = 0;
        for (i = 0; i < n_tests; i++) begin
            total_checks += checks[i];
            total_errs   += errs[i];
        end
        $display("%0d tests, %0d checks, %0d failed", n_tests, total_checks, total_errs);
        if (total_errs == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk_pix);
            cycles++;
        end
        $display("timeout: the checks did not finish within %0d clock cycles", cycles);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* files.f */
+incdir+include
hw/display_pkg.sv
hw/display.sv
hw/test_pattern.sv
hw/sync_align.sv
hw/display_top.sv
tests/display_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the display testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    -f files.f --top-module display_tb -o display_tb

out=$(./obj_dir/display_tb)
echo "$out"

# the run passes only if the pass line was printed
echo "$out" | grep -qx "NO ERRORS"
